/* hw/roce_pkg.sv */
package roce_pkg;

  // datapath beat
  typedef logic [63:0] data_t;
  typedef logic [7:0] keep_t;

  // byte lengths and transfer counts
  typedef logic [31:0] dma_len_t;

  // queue pair fields
  typedef logic [23:0] psn_t;
  typedef logic [63:0] vaddr_t;

  typedef logic [15:0] udp_port_t;

  // path MTU in bytes, 256 up to 4096
  typedef logic [12:0] pmtu_t;

  // IANA port for RoCE v2
  localparam udp_port_t ROCE_UDP_PORT = 16'd4791;

  localparam int BEAT_BYTES = 8;

  // payload route of the rx steering
  typedef enum logic [1:0] {
    route_idle,
    route_cm,
    route_roce
  } route_t;

  typedef enum logic {
    gen_idle,
    gen_run
  } gen_state_t;

endpackage

/* hw/udp_rx_steer.sv */
`timescale 1ns/1ps

module udp_rx_steer (
  input  logic                clk,
  input  logic                rst,
  input  logic                rx_hdr_valid,
  output logic                rx_hdr_ready,
  input  roce_pkg::udp_port_t rx_dest_port,
  input  logic                rx_payload_valid,
  output logic                rx_payload_ready,
  input  logic                rx_payload_last,
  output logic                roce_hdr_valid,
  input  logic                roce_hdr_ready,
  output logic                cm_hdr_valid,
  input  logic                cm_hdr_ready,
  output logic                roce_payload_valid,
  input  logic                roce_payload_ready,
  output logic                cm_payload_valid,
  input  logic                cm_payload_ready
);

  logic             sel_roce;
  logic             last_beat;
  roce_pkg::route_t route;

  assign sel_roce  = (rx_dest_port == roce_pkg::ROCE_UDP_PORT);
  assign last_beat = rx_payload_valid && rx_payload_ready && rx_payload_last;

  // header goes straight through, no latency
  assign roce_hdr_valid = rx_hdr_valid && sel_roce;
  assign cm_hdr_valid   = rx_hdr_valid && !sel_roce;
  assign rx_hdr_ready   = sel_roce ? roce_hdr_ready : cm_hdr_ready;

  // route picked at frame start, held until the last beat
  always_ff @(posedge clk) begin
    if (rst) begin
      route <= roce_pkg::route_idle;
    end else if (rx_payload_valid) begin
      if (route == roce_pkg::route_idle || last_beat) begin
        route <= sel_roce ? roce_pkg::route_roce : roce_pkg::route_cm;
      end
    end else begin
      route <= roce_pkg::route_idle;
    end
  end

  assign roce_payload_valid = rx_payload_valid && (route == roce_pkg::route_roce);
  assign cm_payload_valid   = rx_payload_valid && (route == roce_pkg::route_cm);

  // stall the source with the selected sink
  assign rx_payload_ready = ((route == roce_pkg::route_roce) && roce_payload_ready) ||
                            ((route == roce_pkg::route_cm) && cm_payload_ready);

  a_one_sink: assert property (
    @(posedge clk) disable iff (rst)
    !(roce_payload_valid && cm_payload_valid)
  );

endmodule

/* hw/payload_gen.sv */
`timescale 1ns/1ps

module payload_gen (
  input  logic               clk,
  input  logic               rst,
  input  logic               msg_start,
  input  roce_pkg::dma_len_t dma_length,
  output roce_pkg::data_t    tx_data,
  output roce_pkg::keep_t    tx_keep,
  output logic               tx_valid,
  input  logic               tx_ready,
  output logic               tx_last,
  output logic               message_done
);

  roce_pkg::gen_state_t state;
  roce_pkg::dma_len_t   len_reg;
  roce_pkg::dma_len_t   byte_cnt;
  roce_pkg::keep_t      tail_keep;
  logic [32:0]          next_cnt;
  logic                 beat_done;

  assign beat_done    = tx_valid && tx_ready;
  assign message_done = beat_done && tx_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= roce_pkg::gen_idle;
    end else begin
      case (state)
        roce_pkg::gen_idle: begin
          if (msg_start) begin
            state <= roce_pkg::gen_run;
          end
        end
        roce_pkg::gen_run: begin
          if (message_done) begin
            state <= roce_pkg::gen_idle;
          end
        end
        default: state <= roce_pkg::gen_idle;
      endcase
    end
  end

  // byte offset of the current beat
  always_ff @(posedge clk) begin
    if (msg_start && state == roce_pkg::gen_idle) begin
      len_reg  <= dma_length;
      byte_cnt <= '0;
    end else if (beat_done) begin
      byte_cnt <= byte_cnt + roce_pkg::dma_len_t'(roce_pkg::BEAT_BYTES);
    end
  end

  // one extra bit so the compare survives a wrap near 4 GiB
  assign next_cnt = {1'b0, byte_cnt} + 33'(roce_pkg::BEAT_BYTES);

  // low bytes of a short tail, full beat when aligned
  assign tail_keep = (len_reg[2:0] == 3'd0) ? '1 : ~(8'hff << len_reg[2:0]);

  assign tx_valid = (state == roce_pkg::gen_run);
  assign tx_last  = (next_cnt >= {1'b0, len_reg});
  assign tx_data  = {~byte_cnt, byte_cnt};
  assign tx_keep  = tx_last ? tail_keep : '1;

  a_hold_beat: assert property (
    @(posedge clk) disable iff (rst)
    tx_valid && !tx_ready |=>
      tx_valid && $stable(tx_data) && $stable(tx_keep) && $stable(tx_last)
  );

endmodule

/* hw/transfer_sequencer.sv */
`timescale 1ns/1ps

module transfer_sequencer (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               stop,
  input  roce_pkg::dma_len_t n_transfers,
  input  logic               message_done,
  output logic               msg_start,
  output logic               busy,
  output roce_pkg::dma_len_t messages_sent
);

  roce_pkg::dma_len_t n_reg;
  roce_pkg::dma_len_t next_count;
  logic               first_ok;

  assign next_count = messages_sent + roce_pkg::dma_len_t'(1);
  assign first_ok   = (n_transfers != '0) && !stop;

  always_ff @(posedge clk) begin
    if (rst) begin
      msg_start     <= 1'b0;
      busy          <= 1'b0;
      messages_sent <= '0;
      n_reg         <= '0;
    end else begin
      msg_start <= 1'b0;
      if (start) begin
        n_reg         <= n_transfers;
        messages_sent <= '0;
        busy          <= first_ok;
        msg_start     <= first_ok;
      end else begin
        // a message already running when stop hits still counts
        if (message_done) begin
          messages_sent <= next_count;
        end
        if (busy) begin
          if (stop) begin
            busy <= 1'b0;
          end else if (message_done) begin
            if (next_count < n_reg) begin
              msg_start <= 1'b1;
            end else begin
              busy <= 1'b0;
            end
          end
        end
      end
    end
  end

  // relies on the generator finishing one message per msg_start
  a_count_bound: assert property (
    @(posedge clk) disable iff (rst)
    messages_sent <= n_reg
  );

endmodule

/* hw/qp_tracker.sv */
`timescale 1ns/1ps

module qp_tracker #(
  parameter int ADDR_OFFSET_WIDTH = 18
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               message_done,
  input  roce_pkg::dma_len_t dma_length,
  input  roce_pkg::pmtu_t    pmtu,
  input  roce_pkg::psn_t     init_psn,
  input  roce_pkg::vaddr_t   base_addr,
  output roce_pkg::psn_t     cur_psn,
  output roce_pkg::vaddr_t   cur_rem_addr
);

  roce_pkg::dma_len_t           len_reg;
  roce_pkg::vaddr_t             base_reg;
  logic [3:0]                   shift_reg;
  roce_pkg::dma_len_t           len_mask;
  roce_pkg::dma_len_t           pkt_full;
  roce_pkg::psn_t               pkt_count;
  logic [ADDR_OFFSET_WIDTH-1:0] offset;

  function automatic logic [3:0] pmtu_to_shift(input roce_pkg::pmtu_t p);
    case (p)
      13'd256:  return 4'd8;
      13'd512:  return 4'd9;
      13'd1024: return 4'd10;
      13'd2048: return 4'd11;
      default:  return 4'd12;
    endcase
  endfunction

  // message parameters for the whole run
  always_ff @(posedge clk) begin
    if (start) begin
      len_reg   <= dma_length;
      base_reg  <= base_addr;
      shift_reg <= pmtu_to_shift(pmtu);
    end
  end

  // packets per message, rounded up on a partial tail
  assign len_mask  = (roce_pkg::dma_len_t'(1) << shift_reg) - roce_pkg::dma_len_t'(1);
  assign pkt_full  = len_reg >> shift_reg;
  assign pkt_count = roce_pkg::psn_t'(pkt_full) + roce_pkg::psn_t'(|(len_reg & len_mask));

  always_ff @(posedge clk) begin
    if (rst) begin
      cur_psn <= '0;
      offset  <= '0;
    end else if (start) begin
      cur_psn <= init_psn;
      offset  <= '0;
    end else if (message_done) begin
      // both wrap naturally at their widths
      cur_psn <= cur_psn + pkt_count;
      offset  <= offset + len_reg[ADDR_OFFSET_WIDTH-1:0];
    end
  end

  assign cur_rem_addr = base_reg + roce_pkg::vaddr_t'(offset);

  a_pmtu_legal: assert property (
    @(posedge clk) disable iff (rst)
    start |-> pmtu inside {13'd256, 13'd512, 13'd1024, 13'd2048, 13'd4096}
  );

endmodule

/* hw/roce_stack_top.sv */
`timescale 1ns/1ps

module roce_stack_top #(
  parameter int ADDR_OFFSET_WIDTH = 18
) (
  input  logic                clk,
  input  logic                rst,

  // udp receive side
  input  logic                rx_hdr_valid,
  output logic                rx_hdr_ready,
  input  roce_pkg::udp_port_t rx_dest_port,
  input  roce_pkg::data_t     rx_payload_data,
  input  roce_pkg::keep_t     rx_payload_keep,
  input  logic                rx_payload_valid,
  output logic                rx_payload_ready,
  input  logic                rx_payload_last,

  // roce receiver sink
  output logic                roce_hdr_valid,
  input  logic                roce_hdr_ready,
  output roce_pkg::data_t     roce_payload_data,
  output roce_pkg::keep_t     roce_payload_keep,
  output logic                roce_payload_valid,
  input  logic                roce_payload_ready,
  output logic                roce_payload_last,

  // connection manager sink
  output logic                cm_hdr_valid,
  input  logic                cm_hdr_ready,
  output roce_pkg::data_t     cm_payload_data,
  output roce_pkg::keep_t     cm_payload_keep,
  output logic                cm_payload_valid,
  input  logic                cm_payload_ready,
  output logic                cm_payload_last,

  // transfer configuration
  input  logic                start,
  input  logic                stop,
  input  roce_pkg::dma_len_t  dma_length,
  input  roce_pkg::dma_len_t  n_transfers,
  input  roce_pkg::pmtu_t     pmtu,
  input  roce_pkg::psn_t      init_psn,
  input  roce_pkg::vaddr_t    base_addr,

  // payload stream out
  output roce_pkg::data_t     tx_data,
  output roce_pkg::keep_t     tx_keep,
  output logic                tx_valid,
  input  logic                tx_ready,
  output logic                tx_last,

  // status
  output roce_pkg::psn_t      cur_psn,
  output roce_pkg::vaddr_t    cur_rem_addr,
  output logic                busy,
  output roce_pkg::dma_len_t  messages_sent
);

  logic msg_start;
  logic message_done;

  // beat contents fan out to both sinks, only the valids are steered
  assign roce_payload_data = rx_payload_data;
  assign roce_payload_keep = rx_payload_keep;
  assign roce_payload_last = rx_payload_last;
  assign cm_payload_data   = rx_payload_data;
  assign cm_payload_keep   = rx_payload_keep;
  assign cm_payload_last   = rx_payload_last;

  udp_rx_steer udp_rx_steer_inst (
    .clk                (clk),
    .rst                (rst),
    .rx_hdr_valid       (rx_hdr_valid),
    .rx_hdr_ready       (rx_hdr_ready),
    .rx_dest_port       (rx_dest_port),
    .rx_payload_valid   (rx_payload_valid),
    .rx_payload_ready   (rx_payload_ready),
    .rx_payload_last    (rx_payload_last),
    .roce_hdr_valid     (roce_hdr_valid),
    .roce_hdr_ready     (roce_hdr_ready),
    .cm_hdr_valid       (cm_hdr_valid),
    .cm_hdr_ready       (cm_hdr_ready),
    .roce_payload_valid (roce_payload_valid),
    .roce_payload_ready (roce_payload_ready),
    .cm_payload_valid   (cm_payload_valid),
    .cm_payload_ready   (cm_payload_ready)
  );

  transfer_sequencer transfer_sequencer_inst (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .stop          (stop),
    .n_transfers   (n_transfers),
    .message_done  (message_done),
    .msg_start     (msg_start),
    .busy          (busy),
    .messages_sent (messages_sent)
  );

  payload_gen payload_gen_inst (
    .clk          (clk),
    .rst          (rst),
    .msg_start    (msg_start),
    .dma_length   (dma_length),
    .tx_data      (tx_data),
    .tx_keep      (tx_keep),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .tx_last      (tx_last),
    .message_done (message_done)
  );

  qp_tracker #(
    .ADDR_OFFSET_WIDTH (ADDR_OFFSET_WIDTH)
  ) qp_tracker_inst (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .message_done (message_done),
    .dma_length   (dma_length),
    .pmtu         (pmtu),
    .init_psn     (init_psn),
    .base_addr    (base_addr),
    .cur_psn      (cur_psn),
    .cur_rem_addr (cur_rem_addr)
  );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* bench/roce_stack_tb.sv */
`timescale 1ns/1ps

module roce_stack_tb;

  logic                clk;
  logic                rst;
  logic                rx_hdr_valid;
  logic                rx_hdr_ready;
  roce_pkg::udp_port_t rx_dest_port;
  roce_pkg::data_t     rx_payload_data;
  roce_pkg::keep_t     rx_payload_keep;
  logic                rx_payload_valid;
  logic                rx_payload_ready;
  logic                rx_payload_last;
  logic                roce_hdr_valid;
  logic                roce_hdr_ready;
  roce_pkg::data_t     roce_payload_data;
  roce_pkg::keep_t     roce_payload_keep;
  logic                roce_payload_valid;
  logic                roce_payload_ready;
  logic                roce_payload_last;
  logic                cm_hdr_valid;
  logic                cm_hdr_ready;
  roce_pkg::data_t     cm_payload_data;
  roce_pkg::keep_t     cm_payload_keep;
  logic                cm_payload_valid;
  logic                cm_payload_ready;
  logic                cm_payload_last;
  logic                start;
  logic                stop;
  roce_pkg::dma_len_t  dma_length;
  roce_pkg::dma_len_t  n_transfers;
  roce_pkg::pmtu_t     pmtu;
  roce_pkg::psn_t      init_psn;
  roce_pkg::vaddr_t    base_addr;
  roce_pkg::data_t     tx_data;
  roce_pkg::keep_t     tx_keep;
  logic                tx_valid;
  logic                tx_ready;
  logic                tx_last;
  roce_pkg::psn_t      cur_psn;
  roce_pkg::vaddr_t    cur_rem_addr;
  logic                busy;
  roce_pkg::dma_len_t  messages_sent;

  integer      seed = 32'h45f8472b;
  byte         kind_q[$];
  logic [63:0] field_q[$];
  longint      watchdog_cycles;
  logic        limit_ready;
  int          data_errors;
  int          keep_errors;
  int          flag_errors;
  int          psn_errors;
  int          addr_errors;
  int          count_errors;
  int          other_errors;
  int          total_errors;
  int          t;

  tb_clock clock_inst (
    .clk (clk),
    .rst (rst)
  );

  roce_stack_top #(
    .ADDR_OFFSET_WIDTH (18)
  ) roce_stack_top_inst (
    .clk (clk), .rst (rst),
    .rx_hdr_valid (rx_hdr_valid), .rx_hdr_ready (rx_hdr_ready),
    .rx_dest_port (rx_dest_port),
    .rx_payload_data (rx_payload_data), .rx_payload_keep (rx_payload_keep),
    .rx_payload_valid (rx_payload_valid), .rx_payload_ready (rx_payload_ready),
    .rx_payload_last (rx_payload_last),
    .roce_hdr_valid (roce_hdr_valid), .roce_hdr_ready (roce_hdr_ready),
    .roce_payload_data (roce_payload_data), .roce_payload_keep (roce_payload_keep),
    .roce_payload_valid (roce_payload_valid), .roce_payload_ready (roce_payload_ready),
    .roce_payload_last (roce_payload_last),
    .cm_hdr_valid (cm_hdr_valid), .cm_hdr_ready (cm_hdr_ready),
    .cm_payload_data (cm_payload_data), .cm_payload_keep (cm_payload_keep),
    .cm_payload_valid (cm_payload_valid), .cm_payload_ready (cm_payload_ready),
    .cm_payload_last (cm_payload_last),
    .start (start), .stop (stop),
    .dma_length (dma_length), .n_transfers (n_transfers), .pmtu (pmtu),
    .init_psn (init_psn), .base_addr (base_addr),
    .tx_data (tx_data), .tx_keep (tx_keep), .tx_valid (tx_valid),
    .tx_ready (tx_ready), .tx_last (tx_last),
    .cur_psn (cur_psn), .cur_rem_addr (cur_rem_addr),
    .busy (busy), .messages_sent (messages_sent)
  );

  task automatic check_data(input roce_pkg::data_t got, input roce_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      data_errors++;
      $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_keep(input roce_pkg::keep_t got, input roce_pkg::keep_t exp,
                            input string what);
    if (got !== exp) begin
      keep_errors++;
      $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errors++;
      $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_psn(input roce_pkg::psn_t got, input roce_pkg::psn_t exp,
                           input string what);
    if (got !== exp) begin
      psn_errors++;
      $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input roce_pkg::vaddr_t got, input roce_pkg::vaddr_t exp,
                            input string what);
    if (got !== exp) begin
      addr_errors++;
      $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input roce_pkg::dma_len_t got, input roce_pkg::dma_len_t exp,
                             input string what);
    if (got !== exp) begin
      count_errors++;
      $display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  function automatic logic coin_flip();
    return 1'($random(seed));
  endfunction

  function automatic roce_pkg::dma_len_t beats_for(input roce_pkg::dma_len_t len);
    return roce_pkg::dma_len_t'((64'(len) + 64'd7) >> 3);
  endfunction

  // bytes actually used on the final beat
  function automatic roce_pkg::keep_t tail_keep_for(input roce_pkg::dma_len_t len);
    roce_pkg::keep_t k;
    int used;
    int i;
    used = (len % 8 == 0) ? 8 : int'(len % 8);
    k = '0;
    for (i = 0; i < used; i++) begin
      k[i] = 1'b1;
    end
    return k;
  endfunction

  function automatic roce_pkg::data_t rx_word(input roce_pkg::udp_port_t port,
                                              input roce_pkg::dma_len_t idx);
    return {port, 16'hc0de, idx};
  endfunction

  task automatic drive_sink_readies();
    roce_hdr_ready     <= coin_flip();
    cm_hdr_ready       <= coin_flip();
    roce_payload_ready <= coin_flip();
    cm_payload_ready   <= coin_flip();
  endtask

  task automatic drive_rx_beat(input roce_pkg::udp_port_t port, input roce_pkg::dma_len_t idx,
                               input roce_pkg::dma_len_t beats);
    rx_payload_data <= rx_word(port, idx);
    rx_payload_keep <= (idx == beats - 1) ? 8'h0f : 8'hff;
    rx_payload_last <= (idx == beats - 1);
  endtask

  task automatic load_stimulus();
    int          fd;
    int          got;
    string       line;
    byte         kind;
    logic [63:0] f [8];
    int          i;
    fd = $fopen("bench/roce_stack_stim.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("error: cannot open bench/roce_stack_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        got = $fgets(line, fd);
        if (got > 1 && line.getc(0) != "#") begin
          kind = line.getc(0);
          for (i = 0; i < 8; i++) begin
            f[i] = '0;
          end
          if (kind == "T") begin
            got = $sscanf(line, "T %d %d %d %h %h %d %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
          end else if (kind == "R") begin
            got = $sscanf(line, "R %d %d %d", f[0], f[1], f[2]);
            got = (got == 3) ? 8 : got;
          end else begin
            got = 0;
          end
          if (got != 8) begin
            other_errors++;
            $display("error: cannot parse stimulus line: %s", line);
          end else begin
            kind_q.push_back(kind);
            for (i = 0; i < 8; i++) begin
              field_q.push_back(f[i]);
            end
            if (kind == "T") begin
              watchdog_cycles += longint'(beats_for(f[0])) * longint'(f[1]) * 20;
            end else begin
              watchdog_cycles += longint'(f[1]) * 20;
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_tx_test(
    input roce_pkg::dma_len_t len,
    input roce_pkg::dma_len_t count,
    input roce_pkg::pmtu_t    mtu,
    input roce_pkg::psn_t     psn0,
    input roce_pkg::vaddr_t   base,
    input roce_pkg::dma_len_t stop_after,
    input roce_pkg::psn_t     exp_psn,
    input roce_pkg::vaddr_t   exp_addr
  );
    roce_pkg::dma_len_t beat;
    roce_pkg::dma_len_t msgs;
    roce_pkg::dma_len_t exp_msgs;
    roce_pkg::dma_len_t off;
    logic               exp_last;
    int                 cycle;
    logic               finished;
    beat     = '0;
    msgs     = '0;
    cycle    = 0;
    finished = 1'b0;
    exp_msgs = (stop_after != 0 && stop_after < count) ? stop_after : count;
    @(posedge clk);
    start       <= 1'b1;
    stop        <= 1'b0;
    dma_length  <= len;
    n_transfers <= count;
    pmtu        <= mtu;
    init_psn    <= psn0;
    base_addr   <= base;
    tx_ready    <= coin_flip();
    while (!finished) begin
      @(negedge clk);
      if (tx_valid && tx_ready) begin
        off      = beat * 8;
        exp_last = (64'(off) + 64'd8 >= 64'(len));
        check_data(tx_data, {~off, off}, "tx beat data");
        check_bit(tx_last, exp_last, "tx last");
        check_keep(tx_keep, exp_last ? tail_keep_for(len) : 8'hff, "tx keep");
        if (tx_last) begin
          check_count(beat + 1, beats_for(len), "beats in message");
          beat = '0;
          msgs = msgs + 1;
        end else begin
          beat = beat + 1;
        end
      end
      if (cycle > 0 && !busy && !tx_valid) begin
        finished = 1'b1;
      end else begin
        @(posedge clk);
        start    <= 1'b0;
        tx_ready <= coin_flip();
        // stop lands while the last wanted message is starting
        if (stop_after != 0 && msgs + 1 >= stop_after) begin
          stop <= 1'b1;
        end
        cycle++;
      end
    end
    check_count(messages_sent, exp_msgs, "messages_sent");
    check_count(msgs, exp_msgs, "messages seen on tx");
    check_psn(cur_psn, exp_psn, "final psn");
    check_addr(cur_rem_addr, exp_addr, "final remote address");
  endtask

  task automatic run_rx_frame(input roce_pkg::udp_port_t port,
                              input roce_pkg::dma_len_t beats, input logic to_roce);
    roce_pkg::dma_len_t sent;
    roce_pkg::dma_len_t delivered;
    logic               hdr_done;
    logic               sink_valid;
    logic               sink_ready;
    logic               wrong_valid;
    sent      = '0;
    delivered = '0;
    hdr_done  = 1'b0;
    @(posedge clk);
    rx_dest_port <= port;
    rx_hdr_valid <= 1'b1;
    drive_sink_readies();
    while (!hdr_done) begin
      @(negedge clk);
      check_bit(roce_hdr_valid, to_roce, "roce header valid");
      check_bit(cm_hdr_valid, !to_roce, "cm header valid");
      check_bit(rx_hdr_ready, to_roce ? roce_hdr_ready : cm_hdr_ready, "rx header ready");
      hdr_done = rx_hdr_valid && rx_hdr_ready;
      @(posedge clk);
      drive_sink_readies();
    end
    rx_hdr_valid     <= 1'b0;
    rx_payload_valid <= 1'b1;
    drive_rx_beat(port, '0, beats);
    while (sent < beats) begin
      @(negedge clk);
      sink_valid  = to_roce ? roce_payload_valid : cm_payload_valid;
      sink_ready  = to_roce ? roce_payload_ready : cm_payload_ready;
      wrong_valid = to_roce ? cm_payload_valid : roce_payload_valid;
      check_bit(wrong_valid, 1'b0, "payload valid on wrong sink");
      if (sink_valid && sink_ready) begin
        check_data(to_roce ? roce_payload_data : cm_payload_data,
                   rx_word(port, delivered), "rx sink data");
        check_keep(to_roce ? roce_payload_keep : cm_payload_keep,
                   (delivered == beats - 1) ? 8'h0f : 8'hff, "rx sink keep");
        check_bit(to_roce ? roce_payload_last : cm_payload_last,
                  delivered == beats - 1, "rx sink last");
        delivered = delivered + 1;
      end
      if (rx_payload_valid && rx_payload_ready) begin
        sent = sent + 1;
      end
      @(posedge clk);
      drive_sink_readies();
      if (sent == beats) begin
        rx_payload_valid <= 1'b0;
        rx_payload_last  <= 1'b0;
      end else begin
        drive_rx_beat(port, sent, beats);
      end
    end
    check_count(delivered, beats, "beats delivered to sink");
  endtask

  initial begin
    rx_hdr_valid       = 1'b0;
    rx_dest_port       = '0;
    rx_payload_data    = '0;
    rx_payload_keep    = '0;
    rx_payload_valid   = 1'b0;
    rx_payload_last    = 1'b0;
    roce_hdr_ready     = 1'b0;
    roce_payload_ready = 1'b0;
    cm_hdr_ready       = 1'b0;
    cm_payload_ready   = 1'b0;
    start              = 1'b0;
    stop               = 1'b0;
    dma_length         = 32'd8;
    n_transfers        = '0;
    pmtu               = 13'd256;
    init_psn           = '0;
    base_addr          = '0;
    tx_ready           = 1'b0;
    limit_ready        = 1'b0;
    watchdog_cycles    = 0;
    load_stimulus();
    watchdog_cycles += 1000;
    limit_ready = 1'b1;
    @(posedge clk);
    while (rst) begin
      @(posedge clk);
    end
    for (t = 0; t < kind_q.size(); t++) begin
      if (kind_q[t] == "T") begin
        run_tx_test(field_q[t*8], field_q[t*8+1], field_q[t*8+2], field_q[t*8+3],
                    field_q[t*8+4], field_q[t*8+5], field_q[t*8+6], field_q[t*8+7]);
      end else begin
        run_rx_frame(field_q[t*8], field_q[t*8+1], field_q[t*8+2][0]);
      end
    end
    repeat (2) @(posedge clk);
    total_errors = data_errors + keep_errors + flag_errors + psn_errors + addr_errors +
                   count_errors + other_errors;
    $display("errors: data %0d, keep %0d, flag %0d, psn %0d, addr %0d, count %0d, other %0d",
             data_errors, keep_errors, flag_errors, psn_errors, addr_errors,
             count_errors, other_errors);
    if (total_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // limit scales with the beats in the stimulus file
  initial begin
    wait (limit_ready);
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* roce_stack.f */
hw/roce_pkg.sv
hw/udp_rx_steer.sv
hw/payload_gen.sv
hw/transfer_sequencer.sv
hw/qp_tracker.sv
hw/roce_stack_top.sv
bench/tb_clock.sv
bench/roce_stack_tb.sv

/* bench/roce_stack_stim.txt */
# T len n_transfers pmtu init_psn(hex) base_addr(hex) stop_after exp_psn(hex) exp_addr(hex)
# R dest_port beats exp_sink (1 roce, 0 cm), decimal
T 1 3 256 000010 0000000010000000 0 000013 0000000010000003
R 4791 4 1
T 8 2 512 000100 0000000100000000 0 000102 0000000100000010
R 53 3 0
T 13 4 1024 fffffe 0000000080000000 0 000002 0000000080000034
T 300 3 256 000200 000000ab00000000 0 000206 000000ab00000384
R 4791 1 1
T 4096 2 4096 00abcd 1234567800000000 0 00abcf 1234567800002000
T 2049 2 2048 000000 0000000000000000 0 000004 0000000000001002
R 4790 6 0
T 8200 33 1024 7ffff0 0000000040000000 0 800119 0000000040002108
T 100 10 256 000050 0000000000001000 3 000053 000000000000112c
T 600 5 512 001000 0000000200000000 1 001002 0000000200000258
R 4792 2 0
T 24 2 256 000000 0000000000000000 5 000002 0000000000000030
